// File: rtl/aes_kv_pkg.sv
// Shared types and register map; offsets assume a byte-addressed map of at least 8 address bits
`default_nettype none

package aes_kv_pkg;

  // ==================================================
  // Widths
  // ==================================================
  typedef logic [31:0] dword_t;
  typedef logic [4:0]  kv_entry_t;
  typedef logic [2:0]  kv_offset_t;
  typedef logic [1:0]  axi_resp_t;
  typedef logic [7:0]  reg_addr_t;

  localparam int KEY_DWORDS     = 8;
  localparam int NUM_SEED_WORDS = 2;

  typedef logic [KEY_DWORDS*32-1:0]     key_t;
  // SEED1 in the upper word, SEED0 in the lower word
  typedef logic [NUM_SEED_WORDS*32-1:0] seed_t;

  // ==================================================
  // Register map
  // ==================================================
  localparam reg_addr_t ADDR_NAME      = 8'h00;
  localparam reg_addr_t ADDR_VERSION   = 8'h04;
  localparam reg_addr_t ADDR_KV_CTRL   = 8'h10;
  localparam reg_addr_t ADDR_KV_STATUS = 8'h14;
  localparam reg_addr_t ADDR_INTR      = 8'h18;
  localparam reg_addr_t ADDR_SEED0     = 8'h20;
  localparam reg_addr_t ADDR_SEED1     = 8'h24;

  // ASCII "AESK"
  localparam dword_t NAME_VALUE    = 32'h4145534B;
  localparam dword_t VERSION_VALUE = 32'h00010000;

  // Fixed PRNG state until firmware provides a seed
  localparam seed_t PRNG_RESET_STATE = 64'h243F6A8885A308D3;

  localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

  // ==================================================
  // Key vault types
  // ==================================================
  typedef enum logic [7:0] {
    KV_SUCCESS   = 8'h00,
    KV_READ_FAIL = 8'h01
  } kv_error_e;

  typedef enum logic [1:0] {
    KV_IDLE,
    KV_READ,
    KV_DONE
  } kv_state_e;

  // Request to the vault, answered in the same cycle
  typedef struct packed {
    logic       req;
    kv_entry_t  entry;
    kv_offset_t offset;
  } kv_read_req_t;

  typedef struct packed {
    dword_t data;
    logic   error;
  } kv_read_resp_t;

  // Start pulse and entry from the register block
  typedef struct packed {
    logic      read_en;
    kv_entry_t entry;
  } kv_ctrl_t;

  // One dword from client to key buffer
  typedef struct packed {
    logic       en;
    kv_offset_t offset;
    dword_t     data;
  } kv_wr_t;

  typedef struct packed {
    logic valid;
    key_t key;
  } sideload_key_t;

endpackage

`default_nettype wire

// File: rtl/axil_reg_block.sv
// Needs AXIL_ADDR_WIDTH >= 8; full-word offsets only, one outstanding write and one read
`timescale 1ns/1ps
`default_nettype none

module axil_reg_block
  import aes_kv_pkg::*;
#(
  parameter int AXIL_ADDR_WIDTH = 8
) (
  input  wire                        clk,
  input  wire                        reset_n,
  // AXI4-Lite write channels
  input  wire [AXIL_ADDR_WIDTH-1:0]  awaddr_i,
  input  wire                        awvalid_i,
  output logic                       awready_o,
  input  wire dword_t                wdata_i,
  input  wire [3:0]                  wstrb_i,
  input  wire                        wvalid_i,
  output logic                       wready_o,
  output axi_resp_t                  bresp_o,
  output logic                       bvalid_o,
  input  wire                        bready_i,
  // AXI4-Lite read channels
  input  wire [AXIL_ADDR_WIDTH-1:0]  araddr_i,
  input  wire                        arvalid_i,
  output logic                       arready_o,
  output dword_t                     rdata_o,
  output axi_resp_t                  rresp_o,
  output logic                       rvalid_o,
  input  wire                        rready_i,
  // Key vault client side
  input  wire                        kv_ready_i,
  input  wire                        kv_done_i,
  input  wire kv_error_e             kv_error_i,
  output kv_ctrl_t                   kv_ctrl_o,
  // Entropy seed
  output seed_t                      seed_o,
  output logic [NUM_SEED_WORDS-1:0]  seed_wr_o,
  // Interrupts
  output logic                       notif_intr_o,
  output logic                       error_intr_o
);

  typedef logic [AXIL_ADDR_WIDTH-1:0] addr_t;

  logic   wr_go;
  logic   rd_go;
  logic   wr_ctrl;
  logic   wr_intr;
  logic   status_valid_q;
  logic   notif_q;
  logic   error_q;
  dword_t [NUM_SEED_WORDS-1:0] seed_q;
  dword_t    rd_data;
  axi_resp_t rd_resp;

  function automatic logic is_mapped(input addr_t addr);
    case (addr)
      addr_t'(ADDR_NAME), addr_t'(ADDR_VERSION), addr_t'(ADDR_KV_CTRL),
      addr_t'(ADDR_KV_STATUS), addr_t'(ADDR_INTR),
      addr_t'(ADDR_SEED0), addr_t'(ADDR_SEED1): is_mapped = 1'b1;
      default: is_mapped = 1'b0;
    endcase
  endfunction

  // Byte-lane merge for partial writes
  function automatic dword_t merge_bytes(input dword_t old, input dword_t wdata,
                                         input logic [3:0] strb);
    dword_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // ==================================================
  // Write channel
  // ==================================================
  // Address and data taken together, held off while B is pending
  assign wr_go     = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_go;
  assign wready_o  = wr_go;

  // Control and interrupt fields all live in byte 0
  assign wr_ctrl = wr_go && (awaddr_i == addr_t'(ADDR_KV_CTRL)) && wstrb_i[0];
  assign wr_intr = wr_go && (awaddr_i == addr_t'(ADDR_INTR)) && wstrb_i[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bvalid_o <= 1'b0;
      bresp_o  <= AXI_RESP_OKAY;
    end else if (wr_go) begin
      bvalid_o <= 1'b1;
      bresp_o  <= is_mapped(awaddr_i) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  // Seed words, one strobe per word toward the PRNG
  for (genvar i = 0; i < NUM_SEED_WORDS; i++) begin : g_seed
    assign seed_wr_o[i] = wr_go && |wstrb_i &&
                          (awaddr_i == addr_t'(ADDR_SEED0 + reg_addr_t'(4 * i)));
    always_ff @(posedge clk) begin
      if (seed_wr_o[i]) seed_q[i] <= merge_bytes(seed_q[i], wdata_i, wstrb_i);
    end
  end
  assign seed_o = seed_q;

  // ==================================================
  // Key vault control and status
  // ==================================================
  // Writes while the client is busy are dropped, entry included
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      kv_ctrl_o      <= '0;
      status_valid_q <= 1'b0;
    end else begin
      kv_ctrl_o.read_en <= wr_ctrl && kv_ready_i && wdata_i[0];
      if (wr_ctrl && kv_ready_i) begin
        kv_ctrl_o.entry <= wdata_i[5:1];
      end
      // New request clears valid, completion sets it
      if (kv_done_i) begin
        status_valid_q <= 1'b1;
      end else if (kv_ctrl_o.read_en) begin
        status_valid_q <= 1'b0;
      end
    end
  end

  // W1C interrupt bits, hardware set wins
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      notif_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      notif_q <= (notif_q && !(wr_intr && wdata_i[0])) ||
                 (kv_done_i && kv_error_i == KV_SUCCESS);
      error_q <= (error_q && !(wr_intr && wdata_i[1])) ||
                 (kv_done_i && kv_error_i != KV_SUCCESS);
    end
  end

  assign notif_intr_o = notif_q;
  assign error_intr_o = error_q;

  // ==================================================
  // Read channel
  // ==================================================
  assign arready_o = !rvalid_o;
  assign rd_go     = arvalid_i && arready_o;

  always_comb begin
    rd_data = '0;
    rd_resp = AXI_RESP_OKAY;
    case (araddr_i)
      addr_t'(ADDR_NAME):      rd_data = NAME_VALUE;
      addr_t'(ADDR_VERSION):   rd_data = VERSION_VALUE;
      // read_en is a pulse, reads back as zero
      addr_t'(ADDR_KV_CTRL):   rd_data = {26'b0, kv_ctrl_o.entry, 1'b0};
      addr_t'(ADDR_KV_STATUS): rd_data = {22'b0, kv_error_i, status_valid_q, kv_ready_i};
      addr_t'(ADDR_INTR):      rd_data = {30'b0, error_q, notif_q};
      addr_t'(ADDR_SEED0):     rd_data = seed_q[0];
      addr_t'(ADDR_SEED1):     rd_data = seed_q[1];
      default:                 rd_resp = AXI_RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid_o <= 1'b0;
    end else if (rd_go) begin
      rvalid_o <= 1'b1;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  // Data held stable until rready
  always_ff @(posedge clk) begin
    if (rd_go) begin
      rdata_o <= rd_data;
      rresp_o <= rd_resp;
    end
  end

endmodule

`default_nettype wire

// File: rtl/kv_read_client.sv
// Vault must answer in the request cycle; no back-pressure, aborts on the first errored beat
`timescale 1ns/1ps
`default_nettype none

module kv_read_client
  import aes_kv_pkg::*;
(
  input  wire                clk,
  input  wire                reset_n,
  input  wire                zeroize_i,
  // Start and entry from registers
  input  wire kv_ctrl_t      kv_ctrl_i,
  // Key vault port
  output kv_read_req_t       kv_read_o,
  input  wire kv_read_resp_t kv_resp_i,
  // Toward key buffer
  output kv_wr_t             kv_wr_o,
  output logic               kv_ready_o,
  output logic               kv_done_o,
  output kv_error_e          kv_error_o
);

  kv_state_e  state_q;
  kv_state_e  state_d;
  kv_entry_t  entry_q;
  kv_offset_t offset_q;
  logic       last_beat;

  assign last_beat = (offset_q == kv_offset_t'(KEY_DWORDS - 1));

  // ==================================================
  // FSM
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      KV_IDLE: if (kv_ctrl_i.read_en) state_d = KV_READ;
      // Stop early on a vault error
      KV_READ: if (kv_resp_i.error || last_beat) state_d = KV_DONE;
      KV_DONE: state_d = KV_IDLE;
      default: state_d = KV_IDLE;
    endcase
    // Zeroize abandons the read, no done pulse
    if (zeroize_i) state_d = KV_IDLE;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q    <= KV_IDLE;
      entry_q    <= '0;
      offset_q   <= '0;
      kv_error_o <= KV_SUCCESS;
    end else begin
      state_q <= state_d;
      if (state_q == KV_IDLE && kv_ctrl_i.read_en) begin
        // Capture entry, restart from dword 0
        entry_q    <= kv_ctrl_i.entry;
        offset_q   <= '0;
        kv_error_o <= KV_SUCCESS;
      end else if (state_q == KV_READ) begin
        offset_q <= offset_q + 1'b1;
        if (kv_resp_i.error) kv_error_o <= KV_READ_FAIL;
      end
    end
  end

  // ==================================================
  // Outputs
  // ==================================================
  assign kv_read_o = '{req: (state_q == KV_READ), entry: entry_q, offset: offset_q};

  // Returned dword forwarded in the same cycle, errored beats dropped
  assign kv_wr_o = '{en:     (state_q == KV_READ) && !kv_resp_i.error,
                     offset: offset_q,
                     data:   kv_resp_i.data};

  assign kv_ready_o = (state_q == KV_IDLE);
  assign kv_done_o  = (state_q == KV_DONE);

endmodule

`default_nettype wire

// File: rtl/key_buffer.sv
// Key dwords arrive in offset order starting at 0; key_o is only valid after a clean read
`timescale 1ns/1ps
`default_nettype none

module key_buffer
  import aes_kv_pkg::*;
(
  input  wire            clk,
  input  wire            reset_n,
  input  wire            zeroize_i,
  input  wire kv_wr_t    kv_wr_i,
  input  wire            kv_start_i,
  input  wire            kv_done_i,
  input  wire kv_error_e kv_error_i,
  output sideload_key_t  key_o
);

  dword_t [KEY_DWORDS-1:0] store_q;
  dword_t                  swapped;
  logic                    key_clear;

  // Vault byte order is reversed relative to the cipher core
  assign swapped = {kv_wr_i.data[7:0], kv_wr_i.data[15:8],
                    kv_wr_i.data[23:16], kv_wr_i.data[31:24]};

  // ==================================================
  // Dword store
  // ==================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      store_q <= '0;
    end else if (zeroize_i) begin
      store_q <= '0;
    end else if (kv_wr_i.en) begin
      for (int i = 0; i < KEY_DWORDS; i++) begin
        if (kv_wr_i.offset == kv_offset_t'(i)) begin
          store_q[i] <= swapped;
        end else if (kv_wr_i.offset == '0) begin
          // First beat wipes the rest of an older key
          store_q[i] <= '0;
        end
      end
    end
  end

  // ==================================================
  // Sideload key
  // ==================================================
  assign key_clear = zeroize_i || kv_start_i || (kv_done_i && kv_error_i != KV_SUCCESS);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_o <= '0;
    end else if (key_clear) begin
      key_o <= '0;
    end else if (kv_done_i) begin
      key_o.valid <= 1'b1;
      key_o.key   <= store_q;
    end
  end

endmodule

`default_nettype wire

// File: rtl/entropy_prng.sv
// Xorshift64 is not cryptographic; reseeds only once every seed word has been written
`timescale 1ns/1ps
`default_nettype none

module entropy_prng
  import aes_kv_pkg::*;
(
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire seed_t                seed_i,
  input  wire [NUM_SEED_WORDS-1:0]  seed_wr_i,
  input  wire                       ent_req_i,
  output logic                      ent_ack_o,
  output dword_t                    ent_data_o
);

  logic [NUM_SEED_WORDS-1:0] seed_marks_q;
  logic                      reseed;
  seed_t                     state_q;
  seed_t                     state_step;

  function automatic seed_t xorshift64(input seed_t s);
    seed_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // Reseed once all words are marked, marks clear at the same time
  assign reseed = &seed_marks_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seed_marks_q <= '0;
    end else if (reseed) begin
      seed_marks_q <= '0;
    end else begin
      seed_marks_q <= seed_marks_q | seed_wr_i;
    end
  end

  // No entropy served in the reseed cycle
  assign ent_ack_o  = ent_req_i && !reseed;
  assign state_step = xorshift64(state_q);
  assign ent_data_o = state_step[31:0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= PRNG_RESET_STATE;
    end else if (reseed) begin
      state_q <= seed_i;
    end else if (ent_ack_o) begin
      state_q <= state_step;
    end
  end

endmodule

`default_nettype wire

// File: rtl/aes_kv_top.sv
// Cipher core and key vault sit outside; kv_resp_i must be combinational to kv_read_o
`timescale 1ns/1ps
`default_nettype none

module aes_kv_top
  import aes_kv_pkg::*;
#(
  parameter int AXIL_ADDR_WIDTH = 8
) (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire                        zeroize_i,
  // AXI4-Lite slave
  input  wire [AXIL_ADDR_WIDTH-1:0]  awaddr_i,
  input  wire                        awvalid_i,
  output logic                       awready_o,
  input  wire dword_t                wdata_i,
  input  wire [3:0]                  wstrb_i,
  input  wire                        wvalid_i,
  output logic                       wready_o,
  output axi_resp_t                  bresp_o,
  output logic                       bvalid_o,
  input  wire                        bready_i,
  input  wire [AXIL_ADDR_WIDTH-1:0]  araddr_i,
  input  wire                        arvalid_i,
  output logic                       arready_o,
  output dword_t                     rdata_o,
  output axi_resp_t                  rresp_o,
  output logic                       rvalid_o,
  input  wire                        rready_i,
  // Key vault
  output kv_read_req_t               kv_read_o,
  input  wire kv_read_resp_t         kv_resp_i,
  // Toward the cipher core
  output sideload_key_t              key_o,
  input  wire                        ent_req_i,
  output logic                       ent_ack_o,
  output dword_t                     ent_data_o,
  output logic                       notif_intr_o,
  output logic                       error_intr_o,
  output logic                       busy_o
);

  kv_ctrl_t                  kv_ctrl;
  kv_wr_t                    kv_wr;
  logic                      kv_ready;
  logic                      kv_done;
  kv_error_e                 kv_error;
  seed_t                     seed;
  logic [NUM_SEED_WORDS-1:0] seed_wr;

  assign busy_o = !kv_ready;

  // ==================================================
  // Host registers
  // ==================================================
  axil_reg_block #(
    .AXIL_ADDR_WIDTH (AXIL_ADDR_WIDTH)
  ) u_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .kv_ready_i   (kv_ready),
    .kv_done_i    (kv_done),
    .kv_error_i   (kv_error),
    .kv_ctrl_o    (kv_ctrl),
    .seed_o       (seed),
    .seed_wr_o    (seed_wr),
    .notif_intr_o (notif_intr_o),
    .error_intr_o (error_intr_o)
  );

  // ==================================================
  // Key path
  // ==================================================
  kv_read_client u_kv_client (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize_i  (zeroize_i),
    .kv_ctrl_i  (kv_ctrl),
    .kv_read_o  (kv_read_o),
    .kv_resp_i  (kv_resp_i),
    .kv_wr_o    (kv_wr),
    .kv_ready_o (kv_ready),
    .kv_done_o  (kv_done),
    .kv_error_o (kv_error)
  );

  // Start pulse also invalidates the old key
  key_buffer u_key_buf (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize_i  (zeroize_i),
    .kv_wr_i    (kv_wr),
    .kv_start_i (kv_ctrl.read_en),
    .kv_done_i  (kv_done),
    .kv_error_i (kv_error),
    .key_o      (key_o)
  );

  // Entropy for the cipher core masking
  entropy_prng u_prng (
    .clk        (clk),
    .reset_n    (reset_n),
    .seed_i     (seed),
    .seed_wr_i  (seed_wr),
    .ent_req_i  (ent_req_i),
    .ent_ack_o  (ent_ack_o),
    .ent_data_o (ent_data_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_aes_kv.sv
// Uses the default 8-bit AXI map; key vault modelled here, host always ready on B and R
`timescale 1ns/1ps
`default_nettype none

module tb_aes_kv
  import aes_kv_pkg::*;
();

  localparam int AW         = 8;
  localparam int CLK_PERIOD = 100;
  localparam int SAMPLE_DLY = 10;
  localparam int TIMEOUT    = 200;
  localparam int GOOD_READS = 20;

  logic          clk;
  logic          reset_n;
  logic          zeroize;
  logic [AW-1:0] awaddr;
  logic          awvalid;
  logic          awready;
  dword_t        wdata;
  logic [3:0]    wstrb;
  logic          wvalid;
  logic          wready;
  axi_resp_t     bresp;
  logic          bvalid;
  logic          bready;
  logic [AW-1:0] araddr;
  logic          arvalid;
  logic          arready;
  dword_t        rdata;
  axi_resp_t     rresp;
  logic          rvalid;
  logic          rready;
  kv_read_req_t  kv_read;
  kv_read_resp_t kv_resp;
  sideload_key_t key;
  logic          ent_req;
  logic          ent_ack;
  dword_t        ent_data;
  logic          notif_intr;
  logic          error_intr;
  logic          busy;

  // Key vault contents, 8 dwords per entry
  dword_t        kv_mem [0:32*KEY_DWORDS-1];
  logic [31:0]   locked;
  integer        seed;
  logic [63:0]   prng_model;

  always #(CLK_PERIOD/2) clk = ~clk;

  aes_kv_top #(
    .AXIL_ADDR_WIDTH (AW)
  ) uut (
    .clk (clk), .reset_n (reset_n), .zeroize_i (zeroize),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .kv_read_o (kv_read), .kv_resp_i (kv_resp), .key_o (key),
    .ent_req_i (ent_req), .ent_ack_o (ent_ack), .ent_data_o (ent_data),
    .notif_intr_o (notif_intr), .error_intr_o (error_intr), .busy_o (busy)
  );

  // ==================================================
  // Key vault model
  // ==================================================
  // Register array, answers in the request cycle
  always_comb begin
    kv_resp.data  = kv_mem[{kv_read.entry, kv_read.offset}];
    kv_resp.error = kv_read.req && locked[kv_read.entry];
  end

  // ==================================================
  // Reference model and checking
  // ==================================================
  function automatic dword_t swap_bytes(input dword_t d);
    dword_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = d[8*(3-b) +: 8];
    end
    return r;
  endfunction

  function automatic logic [63:0] xorshift_step(input logic [63:0] s);
    logic [63:0] t;
    t = s ^ (s << 13);
    t = t ^ (t >> 7);
    t = t ^ (t << 17);
    return t;
  endfunction

  task automatic abort_run(input string why);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
                          name, expected, actual));
    end
  endtask

  // ==================================================
  // AXI4-Lite host
  // ==================================================
  task automatic write_reg(input reg_addr_t addr, input dword_t data, output axi_resp_t resp);
    int waited;
    waited = 0;
    @(negedge clk);
    awaddr  = AW'(addr);
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    // Both readies up together while no response is pending
    #(SAMPLE_DLY);
    compare_value("write address ready", 64'(1), 64'(awready));
    compare_value("write data ready", 64'(1), 64'(wready));
    // Handshake happened on the edge before bvalid shows
    do begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("AXI write response never arrived");
    end while (!bvalid);
    // Ready is a single-cycle pulse
    compare_value("write readies after accept", 64'(0), 64'({awready, wready}));
    resp    = bresp;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output dword_t data, output axi_resp_t resp);
    int waited;
    waited = 0;
    @(negedge clk);
    araddr  = AW'(addr);
    arvalid = 1'b1;
    rready  = 1'b1;
    #(SAMPLE_DLY);
    compare_value("read address ready", 64'(1), 64'(arready));
    do begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("AXI read data never arrived");
    end while (!rvalid);
    // No new address while the response is pending
    compare_value("read ready while pending", 64'(0), 64'(arready));
    data    = rdata;
    resp    = rresp;
    arvalid = 1'b0;
  endtask

  // ==================================================
  // Key load helpers
  // ==================================================
  task automatic pick_entry(input logic want_locked, output kv_entry_t e);
    int tries;
    tries = 0;
    e = kv_entry_t'($random(seed));
    while (locked[e] != want_locked) begin
      tries++;
      if (tries > 1000) abort_run("no suitable key-vault entry found");
      e = kv_entry_t'($random(seed));
    end
  endtask

  task automatic start_read(input kv_entry_t e);
    axi_resp_t resp;
    write_reg(ADDR_KV_CTRL, {26'b0, e, 1'b1}, resp);
    compare_value("control write response", 64'(AXI_RESP_OKAY), 64'(resp));
  endtask

  task automatic wait_status_valid(output dword_t status);
    axi_resp_t resp;
    int        polls;
    polls = 0;
    read_reg(ADDR_KV_STATUS, status, resp);
    while (!status[1]) begin
      polls++;
      if (polls > TIMEOUT) abort_run("status valid never set after a key read");
      read_reg(ADDR_KV_STATUS, status, resp);
    end
    compare_value("status read response", 64'(AXI_RESP_OKAY), 64'(resp));
  endtask

  task automatic wait_busy();
    int waited;
    waited = 0;
    while (!busy) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("client never became busy");
    end
  endtask

  // Completed read must give the swapped vault key and a notif interrupt
  task automatic check_good_key(input kv_entry_t e, input string name);
    dword_t    status;
    dword_t    expected;
    axi_resp_t resp;
    wait_status_valid(status);
    compare_value({name, " error code"}, 64'(KV_SUCCESS), 64'(status[9:2]));
    compare_value({name, " key valid"}, 64'(1), 64'(key.valid));
    for (int i = 0; i < KEY_DWORDS; i++) begin
      expected = swap_bytes(kv_mem[{e, kv_offset_t'(i)}]);
      compare_value($sformatf("%s key dword %0d", name, i), 64'(expected),
                    64'(key.key[32*i +: 32]));
    end
    compare_value({name, " notif set"}, 64'(1), 64'(notif_intr));
    write_reg(ADDR_INTR, 32'h1, resp);
    compare_value({name, " notif cleared"}, 64'(0), 64'(notif_intr));
  endtask

  // ==================================================
  // Entropy helpers
  // ==================================================
  task automatic fetch_entropy(output dword_t word);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    @(negedge clk);
    ent_req = 1'b1;
    // Ack is combinational, sampled well away from the edges
    while (!got) begin
      #(SAMPLE_DLY);
      if (ent_ack) begin
        word = ent_data;
        got  = 1'b1;
      end else begin
        waited++;
        if (waited > TIMEOUT) abort_run("entropy request never acknowledged");
        @(negedge clk);
      end
    end
    @(negedge clk);
    ent_req = 1'b0;
  endtask

  task automatic check_entropy(input int count, input logic gaps, input string name);
    dword_t word;
    int     gap;
    for (int n = 0; n < count; n++) begin
      fetch_entropy(word);
      prng_model = xorshift_step(prng_model);
      compare_value($sformatf("%s word %0d", name, n), 64'(prng_model[31:0]), 64'(word));
      gap = gaps ? ($random(seed) & 3) : 0;
      repeat (gap) @(negedge clk);
    end
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    dword_t    data;
    dword_t    seed0;
    dword_t    seed1;
    axi_resp_t resp;
    kv_entry_t entry_a;
    kv_entry_t entry_b;
    seed    = 32'h681c;
    clk     = 1'b0;
    reset_n = 1'b0;
    zeroize = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    ent_req = 1'b0;
    for (int i = 0; i < 32*KEY_DWORDS; i++) begin
      kv_mem[i] = $random(seed);
    end
    // Roughly a quarter of the entries locked
    locked = $random(seed) & $random(seed);
    if (locked == '0) locked[0] = 1'b1;
    if (&locked) locked[1] = 1'b0;

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    compare_value("reset bvalid", 64'(0), 64'(bvalid));
    compare_value("reset rvalid", 64'(0), 64'(rvalid));
    compare_value("reset key valid", 64'(0), 64'(key.valid));
    compare_value("reset vault req", 64'(0), 64'(kv_read.req));
    compare_value("reset interrupts", 64'(0), 64'({error_intr, notif_intr}));
    compare_value("reset busy", 64'(0), 64'(busy));

    // Identification and decode
    read_reg(ADDR_NAME, data, resp);
    compare_value("NAME value", 64'(NAME_VALUE), 64'(data));
    compare_value("NAME response", 64'(AXI_RESP_OKAY), 64'(resp));
    read_reg(ADDR_VERSION, data, resp);
    compare_value("VERSION value", 64'(VERSION_VALUE), 64'(data));
    compare_value("VERSION response", 64'(AXI_RESP_OKAY), 64'(resp));
    read_reg(8'h3C, data, resp);
    compare_value("unmapped read response", 64'(AXI_RESP_SLVERR), 64'(resp));
    write_reg(8'h3C, 32'hDEADBEEF, resp);
    compare_value("unmapped write response", 64'(AXI_RESP_SLVERR), 64'(resp));
    read_reg(ADDR_KV_STATUS, data, resp);
    compare_value("reset status ready", 64'(1), 64'(data[0]));

    // Good reads from random unlocked entries
    for (int n = 0; n < GOOD_READS; n++) begin
      pick_entry(1'b0, entry_a);
      start_read(entry_a);
      check_good_key(entry_a, $sformatf("good read %0d", n));
    end

    // Locked entry aborts the read
    pick_entry(1'b1, entry_a);
    start_read(entry_a);
    wait_status_valid(data);
    compare_value("locked error code", 64'(KV_READ_FAIL), 64'(data[9:2]));
    compare_value("locked key valid", 64'(0), 64'(key.valid));
    compare_value("locked error intr", 64'(1), 64'(error_intr));
    compare_value("locked notif intr", 64'(0), 64'(notif_intr));
    write_reg(ADDR_INTR, 32'h2, resp);
    compare_value("error intr cleared", 64'(0), 64'(error_intr));
    pick_entry(1'b0, entry_a);
    start_read(entry_a);
    check_good_key(entry_a, "recovery read");

    // Control write during a read is dropped
    pick_entry(1'b0, entry_a);
    pick_entry(1'b0, entry_b);
    while (entry_b == entry_a) pick_entry(1'b0, entry_b);
    start_read(entry_a);
    wait_busy();
    write_reg(ADDR_KV_CTRL, {26'b0, entry_b, 1'b1}, resp);
    compare_value("busy write response", 64'(AXI_RESP_OKAY), 64'(resp));
    check_good_key(entry_a, "busy write");
    read_reg(ADDR_KV_CTRL, data, resp);
    compare_value("busy write entry", 64'(entry_a), 64'(data[5:1]));

    // Zeroize drops the key, next read is clean
    @(negedge clk);
    zeroize = 1'b1;
    @(negedge clk);
    zeroize = 1'b0;
    compare_value("zeroize key valid", 64'(0), 64'(key.valid));
    pick_entry(1'b0, entry_a);
    start_read(entry_a);
    check_good_key(entry_a, "after zeroize");

    // Entropy before seeding, after half a seed, after full reseed
    prng_model = PRNG_RESET_STATE;
    check_entropy(6, 1'b0, "unseeded entropy");
    seed0 = $random(seed);
    write_reg(ADDR_SEED0, seed0, resp);
    compare_value("SEED0 write response", 64'(AXI_RESP_OKAY), 64'(resp));
    check_entropy(4, 1'b0, "half seeded entropy");
    seed1 = $random(seed);
    write_reg(ADDR_SEED1, seed1, resp);
    compare_value("SEED1 write response", 64'(AXI_RESP_OKAY), 64'(resp));
    prng_model = {seed1, seed0};
    check_entropy(12, 1'b1, "reseeded entropy");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: aes_kv.f
rtl/aes_kv_pkg.sv
rtl/axil_reg_block.sv
rtl/kv_read_client.sv
rtl/key_buffer.sv
rtl/entropy_prng.sv
rtl/aes_kv_top.sv
tb/tb_aes_kv.sv

// File: Makefile
# Verilator build and run for the AES key-vault wrapper

VERILATOR  ?= verilator
TOP        ?= tb_aes_kv
RTL_TOP    ?= aes_kv_top
FILELIST   ?= aes_kv.f
BUILD_DIR  ?= obj_dir
# Runtime options for the Verilator model's own random engine
SEED_FLAGS ?= +verilator+seed+1
VFLAGS     ?= --binary --timing -j 0

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# Exit status of the model decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
